/* all.f */
+incdir+design
design/tile_mem_pkg.sv
design/tile_axi_pkg.sv
design/tile_data_decode.sv
design/l1_spm.sv
design/l2_axil_bridge.sv
design/tile_rsp_merge.sv
design/tile_data_top.sv
bench/tile_checker.sv
bench/tb_tile.sv

/* bench/tb_tile.sv */
/*
 * Tile data path testbench
 * Applies a request table to the core port and models the AXI4-Lite L2 slave
 */

`default_nettype none
`timescale 1ns/100ps

`include "tile_settings.svh"

module tb_tile;

  localparam int                  GNT_LIMIT   = 40;  // Cycles to wait for a grant
  localparam int                  DRAIN_LIMIT = 60;  // Cycles to wait for open responses
  localparam int                  L2_WORDS    = 64;  // Words in the slave model
  localparam tile_mem_pkg::addr_t L1          = `TILE_L1_BASE;
  localparam tile_mem_pkg::addr_t L2          = `TILE_L2_BASE;

  typedef struct packed {
    tile_mem_pkg::addr_t addr;
    logic                we;
    tile_mem_pkg::strb_t be;
    tile_mem_pkg::data_t wdata;
    tile_mem_pkg::data_t exp_rdata;
    logic                exp_err;
    logic                hold_off;  // Request waits while the tile is disabled
  } entry_t;

  logic clk = 1'b0;
  logic rstn;
  logic tile_enable;
  logic req;
  logic we;
  logic gnt;
  logic rvalid;
  logic err;
  logic exp_err;
  tile_mem_pkg::addr_t addr;
  tile_mem_pkg::strb_t be;
  tile_mem_pkg::data_t wdata;
  tile_mem_pkg::data_t rdata;
  tile_mem_pkg::data_t exp_rdata;
  // AXI4-Lite master side
  tile_mem_pkg::addr_t      m_awaddr;
  tile_mem_pkg::addr_t      m_araddr;
  tile_mem_pkg::data_t      m_wdata;
  tile_mem_pkg::strb_t      m_wstrb;
  logic                     m_awvalid;
  logic                     m_wvalid;
  logic                     m_bready;
  logic                     m_arvalid;
  logic                     m_rready;
  // Slave model outputs
  logic                     m_awready = 1'b0;
  logic                     m_wready  = 1'b0;
  logic                     m_bvalid  = 1'b0;
  logic                     m_arready = 1'b0;
  logic                     m_rvalid  = 1'b0;
  tile_axi_pkg::axi_resp_t  m_bresp   = tile_axi_pkg::OKAY;
  tile_axi_pkg::axi_resp_t  m_rresp   = tile_axi_pkg::OKAY;
  tile_mem_pkg::data_t      m_rdata   = '0;
  // Slave model state
  tile_mem_pkg::data_t l2_mem [L2_WORDS];
  tile_mem_pkg::addr_t aw_addr;
  tile_mem_pkg::addr_t ar_addr;
  tile_mem_pkg::data_t w_data;
  tile_mem_pkg::strb_t w_strb;
  logic                aw_got  = 1'b0;  // Address or data accepted, waiting on B or R
  logic                w_got   = 1'b0;
  logic                ar_got  = 1'b0;
  logic                b_taken = 1'b0;  // B handshake at the last rising edge
  logic                r_taken = 1'b0;  // R handshake at the last rising edge
  int                  aw_dly = 0;
  int                  w_dly  = 0;
  int                  b_dly  = 0;
  int                  ar_dly = 0;
  int                  r_dly  = 0;
  logic [15:0]         lfsr_q = 16'd4;

  entry_t table_q [$];
  int     chk_pending;
  int     chk_errors;
  int     timeouts = 0;

  always #2 clk = ~clk;  // 4 ns period

  tile_data_top uut (
    .clk_i (clk), .rstn_i (rstn), .tile_enable_i (tile_enable),
    .req_i (req), .addr_i (addr), .we_i (we), .be_i (be), .wdata_i (wdata),
    .gnt_o (gnt), .rvalid_o (rvalid), .rdata_o (rdata), .err_o (err),
    .m_awaddr_o (m_awaddr), .m_awvalid_o (m_awvalid), .m_awready_i (m_awready),
    .m_wdata_o (m_wdata), .m_wstrb_o (m_wstrb), .m_wvalid_o (m_wvalid), .m_wready_i (m_wready),
    .m_bresp_i (m_bresp), .m_bvalid_i (m_bvalid), .m_bready_o (m_bready),
    .m_araddr_o (m_araddr), .m_arvalid_o (m_arvalid), .m_arready_i (m_arready),
    .m_rdata_i (m_rdata), .m_rresp_i (m_rresp), .m_rvalid_i (m_rvalid), .m_rready_o (m_rready)
  );

  tile_checker u_check (
    .clk_i (clk), .rstn_i (rstn), .tile_enable_i (tile_enable),
    .req_i (req), .addr_i (addr), .gnt_i (gnt),
    .rvalid_i (rvalid), .rdata_i (rdata), .err_i (err),
    .exp_rdata_i (exp_rdata), .exp_err_i (exp_err),
    .pending_o (chk_pending), .errors_o (chk_errors)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  task automatic draw_delay(output int d);
    lfsr_q = lfsr_next(lfsr_q);
    d      = int'(lfsr_q[0]);
    lfsr_q = lfsr_next(lfsr_q);
    d      = 2 * d + int'(lfsr_q[0]);  // 0 to 3 cycles
  endtask

  task automatic slave_write();
    tile_mem_pkg::addr_t off;
    off = aw_addr - L2;
    if (off < 32'(L2_WORDS * 4)) begin
      for (int b = 0; b < 4; b++) begin
        if (w_strb[b]) l2_mem[off[7:2]][8*b +: 8] = w_data[8*b +: 8];
      end
      m_bresp = tile_axi_pkg::OKAY;
    end else begin
      m_bresp = tile_axi_pkg::SLVERR;  // Beyond the modelled words
    end
  endtask

  task automatic slave_read();
    tile_mem_pkg::addr_t off;
    off = ar_addr - L2;
    if (off < 32'(L2_WORDS * 4)) begin
      m_rdata = l2_mem[off[7:2]];
      m_rresp = tile_axi_pkg::OKAY;
    end else begin
      m_rdata = '0;
      m_rresp = tile_axi_pkg::SLVERR;
    end
  endtask

  // Response handshakes as the bridge sees them at the rising edge
  always @(posedge clk) begin
    b_taken = m_bvalid && m_bready;
    r_taken = m_rvalid && m_rready;
  end

  // Slave model, a ready or valid raised here is taken at the next rising edge
  always @(negedge clk) begin
    if (rstn) begin
      if (m_awready) begin
        m_awready = 1'b0;
        aw_addr   = m_awaddr;
        aw_got    = 1'b1;
        draw_delay(aw_dly);
      end else if (m_awvalid && !aw_got) begin
        if (aw_dly == 0) m_awready = 1'b1;
        else             aw_dly--;
      end
      if (m_wready) begin
        m_wready = 1'b0;
        w_data   = m_wdata;
        w_strb   = m_wstrb;
        w_got    = 1'b1;
        draw_delay(w_dly);
      end else if (m_wvalid && !w_got) begin
        if (w_dly == 0) m_wready = 1'b1;
        else            w_dly--;
      end
      if (m_bvalid) begin
        if (b_taken) begin
          m_bvalid = 1'b0;  // Held until bready takes it
          aw_got   = 1'b0;
          w_got    = 1'b0;
        end
      end else if (aw_got && w_got) begin
        if (b_dly == 0) begin
          slave_write();
          m_bvalid = 1'b1;
          draw_delay(b_dly);
        end else begin
          b_dly--;
        end
      end
      if (m_arready) begin
        m_arready = 1'b0;
        ar_addr   = m_araddr;
        ar_got    = 1'b1;
        draw_delay(ar_dly);
      end else if (m_arvalid && !ar_got) begin
        if (ar_dly == 0) m_arready = 1'b1;
        else             ar_dly--;
      end
      if (m_rvalid) begin
        if (r_taken) begin
          m_rvalid = 1'b0;  // Held until rready takes it
          ar_got   = 1'b0;
        end
      end else if (ar_got) begin
        if (r_dly == 0) begin
          slave_read();
          m_rvalid = 1'b1;
          draw_delay(r_dly);
        end else begin
          r_dly--;
        end
      end
    end
  end

  task automatic add_entry(input tile_mem_pkg::addr_t a, input logic w,
                           input tile_mem_pkg::strb_t b,
                           input tile_mem_pkg::data_t d, input tile_mem_pkg::data_t x,
                           input logic xe, input logic h);
    table_q.push_back('{a, w, b, d, x, xe, h});
  endtask

  task automatic build_table();
    // Address, write, strobes, write data, expected data, expected error, hold off
    add_entry(L1 + 32'h000, 1'b1, 4'hF, 32'h1111_1111, 32'h0, 1'b0, 1'b0);  // All four banks
    add_entry(L1 + 32'h004, 1'b1, 4'hF, 32'h2222_2222, 32'h0, 1'b0, 1'b0);
    add_entry(L1 + 32'h008, 1'b1, 4'hF, 32'h3333_3333, 32'h0, 1'b0, 1'b0);
    add_entry(L1 + 32'h00C, 1'b1, 4'hF, 32'h4444_4444, 32'h0, 1'b0, 1'b0);
    add_entry(L1 + 32'h7F0, 1'b1, 4'hF, 32'h5555_5555, 32'h0, 1'b0, 1'b0);  // Row 127
    add_entry(L1 + 32'h000, 1'b0, 4'hF, 32'h0, 32'h1111_1111, 1'b0, 1'b0);
    add_entry(L1 + 32'h004, 1'b0, 4'hF, 32'h0, 32'h2222_2222, 1'b0, 1'b0);
    add_entry(L1 + 32'h008, 1'b0, 4'hF, 32'h0, 32'h3333_3333, 1'b0, 1'b0);
    add_entry(L1 + 32'h00C, 1'b0, 4'hF, 32'h0, 32'h4444_4444, 1'b0, 1'b0);
    add_entry(L1 + 32'h7F0, 1'b0, 4'hF, 32'h0, 32'h5555_5555, 1'b0, 1'b0);
    add_entry(L1 + 32'h004, 1'b1, 4'h5, 32'hAABB_CCDD, 32'h0, 1'b0, 1'b0);  // Bytes 0 and 2
    add_entry(L1 + 32'h004, 1'b0, 4'hF, 32'h0, 32'h22BB_22DD, 1'b0, 1'b0);
    add_entry(L1 + 32'h00C, 1'b1, 4'h8, 32'hEE00_0000, 32'h0, 1'b0, 1'b0);
    add_entry(L1 + 32'h00C, 1'b0, 4'hF, 32'h0, 32'hEE44_4444, 1'b0, 1'b0);
    add_entry(L2 + 32'h000, 1'b1, 4'hF, 32'hCAFE_0001, 32'h0, 1'b0, 1'b0);  // AXI4-Lite path
    add_entry(L2 + 32'h004, 1'b1, 4'hF, 32'hCAFE_0002, 32'h0, 1'b0, 1'b0);
    add_entry(L2 + 32'h0FC, 1'b1, 4'hF, 32'hCAFE_003F, 32'h0, 1'b0, 1'b0);  // Last model word
    add_entry(L2 + 32'h004, 1'b1, 4'h3, 32'h0000_BEEF, 32'h0, 1'b0, 1'b0);
    add_entry(L2 + 32'h000, 1'b0, 4'hF, 32'h0, 32'hCAFE_0001, 1'b0, 1'b0);
    add_entry(L2 + 32'h004, 1'b0, 4'hF, 32'h0, 32'hCAFE_BEEF, 1'b0, 1'b0);
    add_entry(L2 + 32'h0FC, 1'b0, 4'hF, 32'h0, 32'hCAFE_003F, 1'b0, 1'b0);
    add_entry(L2 + 32'h100, 1'b1, 4'hF, 32'h1234_5678, 32'h0, 1'b1, 1'b0);  // SLVERR
    add_entry(L2 + 32'h100, 1'b0, 4'hF, 32'h0, 32'h0, 1'b1, 1'b0);
    add_entry(32'h2000_0000, 1'b0, 4'hF, 32'h0, 32'h0, 1'b1, 1'b0);  // Unmapped
    add_entry(32'h0000_1000, 1'b1, 4'hF, 32'hDEAD_BEEF, 32'h0, 1'b1, 1'b0);
    add_entry(L1 + 32'h000, 1'b0, 4'hF, 32'h0, 32'h1111_1111, 1'b0, 1'b0);  // Alternating
    add_entry(L2 + 32'h000, 1'b0, 4'hF, 32'h0, 32'hCAFE_0001, 1'b0, 1'b0);
    add_entry(L1 + 32'h008, 1'b0, 4'hF, 32'h0, 32'h3333_3333, 1'b0, 1'b0);
    add_entry(L2 + 32'h0FC, 1'b0, 4'hF, 32'h0, 32'hCAFE_003F, 1'b0, 1'b0);
    add_entry(L1 + 32'h7F0, 1'b0, 4'hF, 32'h0, 32'h5555_5555, 1'b0, 1'b1);  // Tile disabled
    add_entry(L2 + 32'h004, 1'b0, 4'hF, 32'h0, 32'hCAFE_BEEF, 1'b0, 1'b0);
  endtask

  task automatic finish_run();
    $display("Run ended with %0d check errors and %0d timeouts", chk_errors, timeouts);
    if ((chk_errors == 0) && (timeouts == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic wait_grant();
    int t;
    t = 0;
    @(posedge clk);
    while (!gnt && (t < GNT_LIMIT)) begin
      t++;
      @(posedge clk);
    end
    if (!gnt) begin
      $display("No grant for address %h in time", addr);
      timeouts++;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((chk_pending != 0) && (t < DRAIN_LIMIT)) begin
      t++;
      @(negedge clk);
    end
    if (chk_pending != 0) begin
      $display("Responses still missing at the end of the wait");
      timeouts++;
    end
  endtask

  task automatic apply_entry(input entry_t e);
    @(negedge clk);
    if (e.hold_off) begin
      req         = 1'b0;
      tile_enable = 1'b0;
      @(negedge clk);  // Registered enable falls at this edge
      wait_drain();
    end
    addr      = e.addr;
    we        = e.we;
    be        = e.be;
    wdata     = e.wdata;
    exp_rdata = e.exp_rdata;
    exp_err   = e.exp_err;
    req       = 1'b1;
    if (e.hold_off) begin
      repeat (6) @(negedge clk);  // Checker flags any grant here
      tile_enable = 1'b1;
    end
    wait_grant();
  endtask

  initial begin
    rstn        = 1'b0;
    tile_enable = 1'b1;
    req         = 1'b0;
    addr        = '0;
    we          = 1'b0;
    be          = '0;
    wdata       = '0;
    exp_rdata   = '0;
    exp_err     = 1'b0;
    build_table();
    repeat (5) @(negedge clk);  // Reset for 5 cycles
    rstn = 1'b1;
    for (int i = 0; (i < table_q.size()) && (timeouts == 0); i++) begin
      apply_entry(table_q[i]);
    end
    @(negedge clk);
    req = 1'b0;
    if (timeouts == 0) wait_drain();
    finish_run();
  end

endmodule

`default_nettype wire

/* bench/tile_checker.sv */
/*
 * Response checker
 * Follows grants on the core port and compares each response in grant order
 */

`default_nettype none
`timescale 1ns/100ps

`include "tile_settings.svh"

module tile_checker (
  input  wire logic                clk_i,
  input  wire logic                rstn_i,
  input  wire logic                tile_enable_i,
  input  wire logic                req_i,
  input  wire tile_mem_pkg::addr_t addr_i,
  input  wire logic                gnt_i,
  input  wire logic                rvalid_i,
  input  wire tile_mem_pkg::data_t rdata_i,
  input  wire logic                err_i,
  input  wire tile_mem_pkg::data_t exp_rdata_i,
  input  wire logic                exp_err_i,
  output      int                  pending_o,
  output      int                  errors_o
);

  tile_mem_pkg::data_t exp_data_q [$];  // Expected data in grant order
  logic                exp_err_q  [$];
  int                  gnt_cyc_q  [$];  // Cycle of each grant
  logic                fixed_q    [$];  // Response due one cycle after its grant
  int                  cyc      = 0;
  int                  err_cnt  = 0;
  logic                en_seen  = 1'b0;  // Enable as the decoder holds it

  assign pending_o = exp_data_q.size();
  assign errors_o  = err_cnt;

  task automatic check_response();
    tile_mem_pkg::data_t exp_data;
    logic                exp_err;
    int                  gnt_cyc;
    logic                fixed;
    if (exp_data_q.size() == 0) begin
      $display("Response at cycle %0d arrived without a granted request", cyc);
      err_cnt++;
    end else begin
      exp_data = exp_data_q.pop_front();
      exp_err  = exp_err_q.pop_front();
      gnt_cyc  = gnt_cyc_q.pop_front();
      fixed    = fixed_q.pop_front();
      if (rdata_i !== exp_data) begin
        $display("CHECK FAILED rdata_o expected %h got %h", exp_data, rdata_i);
        err_cnt++;
      end
      if (err_i !== exp_err) begin
        $display("CHECK FAILED err_o expected %h got %h", exp_err, err_i);
        err_cnt++;
      end
      if (fixed && (cyc != gnt_cyc + 1)) begin  // L1 and unmapped answer next cycle
        $display("Response came %0d cycles after its grant instead of 1", cyc - gnt_cyc);
        err_cnt++;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!rstn_i) begin
      en_seen = 1'b0;
    end else begin
      cyc++;
      if (rvalid_i) check_response();  // Retire before booking this edge's grant
      if (req_i && gnt_i) begin
        if (!en_seen) begin
          $display("Grant at cycle %0d while the tile was disabled", cyc);
          err_cnt++;
        end
        exp_data_q.push_back(exp_rdata_i);
        exp_err_q.push_back(exp_err_i);
        gnt_cyc_q.push_back(cyc);
        fixed_q.push_back(!((addr_i >= `TILE_L2_BASE) && (addr_i <= `TILE_L2_END)));
      end
      en_seen = tile_enable_i;  // One cycle behind the input
    end
  end

endmodule

`default_nettype wire

/* design/l1_spm.sv */
/*
 * L1 scratchpad
 * Word-interleaved banks with byte strobes, one cycle read latency
 */

`default_nettype none
`timescale 1ns/100ps

`include "tile_settings.svh"

module l1_spm (
  input  wire logic                clk_i,
  input  wire logic                rstn_i,
  input  wire logic                req_i,
  input  wire tile_mem_pkg::addr_t addr_i,
  input  wire logic                we_i,
  input  wire tile_mem_pkg::strb_t be_i,
  input  wire tile_mem_pkg::data_t wdata_i,
  output      logic                rvalid_o,
  output      tile_mem_pkg::data_t rdata_o
);

  localparam int BANK_LSB = 2;  // Word offset
  localparam int ROW_LSB  = BANK_LSB + $bits(tile_mem_pkg::bank_idx_t);

  tile_mem_pkg::bank_idx_t bank;
  tile_mem_pkg::row_t      row;
  tile_mem_pkg::bank_idx_t bank_q;  // Bank of the pending read
  logic                    we_q;    // Pending access was a write
  tile_mem_pkg::data_t     bank_rdata [`TILE_N_BANKS];

  assign bank = addr_i[BANK_LSB +: $bits(tile_mem_pkg::bank_idx_t)];
  assign row  = addr_i[ROW_LSB +: $bits(tile_mem_pkg::row_t)];

  for (genvar g = 0; g < `TILE_N_BANKS; g++) begin : g_bank
    tile_mem_pkg::data_t mem [`TILE_BANK_WORDS];
    logic                sel;

    assign sel = req_i && (bank == tile_mem_pkg::bank_idx_t'(g));

    always_ff @(posedge clk_i) begin
      if (sel && we_i) begin
        for (int b = 0; b < `TILE_DATA_W/8; b++) begin
          if (be_i[b]) mem[row][8*b +: 8] <= wdata_i[8*b +: 8];  // Only enabled bytes
        end
      end
      if (sel && !we_i) bank_rdata[g] <= mem[row];
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) rvalid_o <= 1'b0;
    else         rvalid_o <= req_i;  // Fixed one cycle latency
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      bank_q <= bank;
      we_q   <= we_i;
    end
  end

  assign rdata_o = we_q ? '0 : bank_rdata[bank_q];  // Writes answer with zero

endmodule

`default_nettype wire

/* design/l2_axil_bridge.sv */
/*
 * L2 AXI4-Lite bridge
 * Turns one core request at a time into an AXI4-Lite transaction
 */

`default_nettype none
`timescale 1ns/100ps

module l2_axil_bridge (
  input  wire logic                    clk_i,
  input  wire logic                    rstn_i,
  input  wire logic                    req_i,
  input  wire tile_mem_pkg::addr_t     addr_i,
  input  wire logic                    we_i,
  input  wire tile_mem_pkg::strb_t     be_i,
  input  wire tile_mem_pkg::data_t     wdata_i,
  output      logic                    ready_o,
  output      logic                    rvalid_o,
  output      tile_mem_pkg::data_t     rdata_o,
  output      logic                    err_o,
  output      tile_mem_pkg::addr_t     m_awaddr_o,
  output      logic                    m_awvalid_o,
  input  wire logic                    m_awready_i,
  output      tile_mem_pkg::data_t     m_wdata_o,
  output      tile_mem_pkg::strb_t     m_wstrb_o,
  output      logic                    m_wvalid_o,
  input  wire logic                    m_wready_i,
  input  wire tile_axi_pkg::axi_resp_t m_bresp_i,
  input  wire logic                    m_bvalid_i,
  output      logic                    m_bready_o,
  output      tile_mem_pkg::addr_t     m_araddr_o,
  output      logic                    m_arvalid_o,
  input  wire logic                    m_arready_i,
  input  wire tile_mem_pkg::data_t     m_rdata_i,
  input  wire tile_axi_pkg::axi_resp_t m_rresp_i,
  input  wire logic                    m_rvalid_i,
  output      logic                    m_rready_o
);

  tile_axi_pkg::bridge_state_e state_q;
  tile_mem_pkg::addr_t         addr_q;   // Latched request
  tile_mem_pkg::data_t         wdata_q;
  tile_mem_pkg::strb_t         be_q;
  logic                        aw_left;  // AW still open after this cycle
  logic                        w_left;

  assign aw_left = m_awvalid_o && !m_awready_i;
  assign w_left  = m_wvalid_o && !m_wready_i;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q     <= tile_axi_pkg::IDLE;
      m_awvalid_o <= 1'b0;
      m_wvalid_o  <= 1'b0;
      m_arvalid_o <= 1'b0;
      rvalid_o    <= 1'b0;
      err_o       <= 1'b0;
    end else begin
      rvalid_o <= 1'b0;  // Single cycle pulse
      case (state_q)
        tile_axi_pkg::IDLE: begin
          if (req_i && we_i) begin
            m_awvalid_o <= 1'b1;  // AW and W go out together
            m_wvalid_o  <= 1'b1;
            state_q     <= tile_axi_pkg::WRITE;
          end else if (req_i) begin
            m_arvalid_o <= 1'b1;
            state_q     <= tile_axi_pkg::READ_ADDR;
          end
        end
        tile_axi_pkg::WRITE: begin
          m_awvalid_o <= aw_left;  // Each valid drops on its own handshake
          m_wvalid_o  <= w_left;
          if (!aw_left && !w_left) state_q <= tile_axi_pkg::WRITE_RESP;
        end
        tile_axi_pkg::WRITE_RESP: begin
          if (m_bvalid_i) begin
            rvalid_o <= 1'b1;
            err_o    <= (m_bresp_i != tile_axi_pkg::OKAY);
            state_q  <= tile_axi_pkg::IDLE;
          end
        end
        tile_axi_pkg::READ_ADDR: begin
          if (m_arready_i) begin
            m_arvalid_o <= 1'b0;
            state_q     <= tile_axi_pkg::READ_DATA;
          end
        end
        tile_axi_pkg::READ_DATA: begin
          if (m_rvalid_i) begin
            rvalid_o <= 1'b1;
            err_o    <= (m_rresp_i != tile_axi_pkg::OKAY);
            state_q  <= tile_axi_pkg::IDLE;
          end
        end
        default: state_q <= tile_axi_pkg::IDLE;
      endcase
    end
  end

  // Payload, no reset needed
  always_ff @(posedge clk_i) begin
    if (ready_o && req_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
    if (state_q == tile_axi_pkg::WRITE_RESP && m_bvalid_i) rdata_o <= '0;  // Write returns zero
    if (state_q == tile_axi_pkg::READ_DATA && m_rvalid_i)  rdata_o <= m_rdata_i;
  end

  assign ready_o    = (state_q == tile_axi_pkg::IDLE);
  assign m_awaddr_o = addr_q;
  assign m_araddr_o = addr_q;
  assign m_wdata_o  = wdata_q;
  assign m_wstrb_o  = be_q;
  assign m_bready_o = (state_q == tile_axi_pkg::WRITE_RESP);  // High for the whole wait
  assign m_rready_o = (state_q == tile_axi_pkg::READ_DATA);

endmodule

`default_nettype wire

/* design/tile_axi_pkg.sv */
/*
 * Tile AXI package
 * AXI4-Lite response codes and the bridge FSM states
 */

`default_nettype none

package tile_axi_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,  // Slave error
    DECERR = 2'b11   // Decode error
  } axi_resp_t;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,       // AW and W in progress
    WRITE_RESP,  // Waiting on B
    READ_ADDR,   // AR in progress
    READ_DATA    // Waiting on R
  } bridge_state_e;

endpackage

`default_nettype wire

/* design/tile_data_decode.sv */
/*
 * Core data port decoder
 * Picks the target from the address map and grants requests
 */

`default_nettype none
`timescale 1ns/100ps

`include "tile_settings.svh"

module tile_data_decode (
  input  wire logic                  clk_i,
  input  wire logic                  rstn_i,
  input  wire logic                  tile_enable_i,
  input  wire logic                  req_i,
  input  wire tile_mem_pkg::addr_t   addr_i,
  input  wire logic                  issue_ok_i,
  input  wire logic                  l2_ready_i,
  output      logic                  gnt_o,
  output      tile_mem_pkg::target_e dec_target_o,
  output      logic                  dec_valid_o,
  output      logic                  l1_req_o,
  output      logic                  l2_req_o
);

  logic                  en_q;         // Registered tile enable
  logic                  hit_l1;
  logic                  hit_l2;
  logic                  target_free;  // Chosen target can take a request now
  tile_mem_pkg::target_e target;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) en_q <= 1'b0;
    else         en_q <= tile_enable_i;
  end

  assign hit_l1 = (addr_i >= `TILE_L1_BASE) && (addr_i <= `TILE_L1_END);
  assign hit_l2 = (addr_i >= `TILE_L2_BASE) && (addr_i <= `TILE_L2_END);

  always_comb begin
    if (hit_l1)      target = tile_mem_pkg::TGT_L1;
    else if (hit_l2) target = tile_mem_pkg::TGT_L2;
    else             target = tile_mem_pkg::TGT_NONE;  // Error response from the merger
  end

  assign target_free = (target != tile_mem_pkg::TGT_L2) || l2_ready_i;  // Bridge takes one at a time

  assign gnt_o        = req_i && en_q && issue_ok_i && target_free;
  assign dec_valid_o  = gnt_o;  // Merger books every granted request
  assign dec_target_o = target;
  assign l1_req_o     = gnt_o && (target == tile_mem_pkg::TGT_L1);
  assign l2_req_o     = gnt_o && (target == tile_mem_pkg::TGT_L2);

endmodule

`default_nettype wire

/* design/tile_data_top.sv */
/*
 * Tile data path top
 * Core data port to L1 scratchpad and AXI4-Lite L2 master
 */

`default_nettype none
`timescale 1ns/100ps

module tile_data_top (
  input  wire logic                    clk_i,
  input  wire logic                    rstn_i,
  input  wire logic                    tile_enable_i,
  // Core data port
  input  wire logic                    req_i,
  input  wire tile_mem_pkg::addr_t     addr_i,
  input  wire logic                    we_i,
  input  wire tile_mem_pkg::strb_t     be_i,
  input  wire tile_mem_pkg::data_t     wdata_i,
  output      logic                    gnt_o,
  output      logic                    rvalid_o,
  output      tile_mem_pkg::data_t     rdata_o,
  output      logic                    err_o,
  // AXI4-Lite master
  output      tile_mem_pkg::addr_t     m_awaddr_o,
  output      logic                    m_awvalid_o,
  input  wire logic                    m_awready_i,
  output      tile_mem_pkg::data_t     m_wdata_o,
  output      tile_mem_pkg::strb_t     m_wstrb_o,
  output      logic                    m_wvalid_o,
  input  wire logic                    m_wready_i,
  input  wire tile_axi_pkg::axi_resp_t m_bresp_i,
  input  wire logic                    m_bvalid_i,
  output      logic                    m_bready_o,
  output      tile_mem_pkg::addr_t     m_araddr_o,
  output      logic                    m_arvalid_o,
  input  wire logic                    m_arready_i,
  input  wire tile_mem_pkg::data_t     m_rdata_i,
  input  wire tile_axi_pkg::axi_resp_t m_rresp_i,
  input  wire logic                    m_rvalid_i,
  output      logic                    m_rready_o
);

  logic                  issue_ok;
  logic                  l2_ready;
  logic                  dec_valid;
  tile_mem_pkg::target_e dec_target;
  logic                  l1_req;      // Scratchpad select strobe
  logic                  l2_req;      // Bridge select strobe
  logic                  l1_rvalid;
  tile_mem_pkg::data_t   l1_rdata;
  logic                  l2_rvalid;
  tile_mem_pkg::data_t   l2_rdata;
  logic                  l2_err;

  tile_data_decode i_decode (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .tile_enable_i (tile_enable_i),
    .req_i         (req_i),
    .addr_i        (addr_i),
    .issue_ok_i    (issue_ok),
    .l2_ready_i    (l2_ready),
    .gnt_o         (gnt_o),
    .dec_target_o  (dec_target),
    .dec_valid_o   (dec_valid),
    .l1_req_o      (l1_req),
    .l2_req_o      (l2_req)
  );

  l1_spm i_l1_spm (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .req_i    (l1_req),
    .addr_i   (addr_i),
    .we_i     (we_i),
    .be_i     (be_i),
    .wdata_i  (wdata_i),
    .rvalid_o (l1_rvalid),
    .rdata_o  (l1_rdata)
  );

  l2_axil_bridge i_l2_bridge (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .req_i       (l2_req),
    .addr_i      (addr_i),
    .we_i        (we_i),
    .be_i        (be_i),
    .wdata_i     (wdata_i),
    .ready_o     (l2_ready),
    .rvalid_o    (l2_rvalid),
    .rdata_o     (l2_rdata),
    .err_o       (l2_err),
    .m_awaddr_o  (m_awaddr_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_bresp_i   (m_bresp_i),
    .m_bvalid_i  (m_bvalid_i),
    .m_bready_o  (m_bready_o),
    .m_araddr_o  (m_araddr_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_rdata_i   (m_rdata_i),
    .m_rresp_i   (m_rresp_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o)
  );

  tile_rsp_merge i_rsp_merge (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .dec_valid_i  (dec_valid),
    .dec_target_i (dec_target),
    .l1_rvalid_i  (l1_rvalid),
    .l1_rdata_i   (l1_rdata),
    .l2_rvalid_i  (l2_rvalid),
    .l2_rdata_i   (l2_rdata),
    .l2_err_i     (l2_err),
    .issue_ok_o   (issue_ok),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .err_o        (err_o)
  );

endmodule

`default_nettype wire

/* design/tile_mem_pkg.sv */
/*
 * Tile memory package
 * Data path types shared by the decoder, scratchpad, bridge and merger
 */

`default_nettype none

`include "tile_settings.svh"

package tile_mem_pkg;

  typedef logic [`TILE_ADDR_W-1:0]              addr_t;      // Byte address
  typedef logic [`TILE_DATA_W-1:0]              data_t;      // Data word
  typedef logic [`TILE_DATA_W/8-1:0]            strb_t;      // Byte enables
  typedef logic [$clog2(`TILE_N_BANKS)-1:0]     bank_idx_t;  // Bank select, addr[3:2]
  typedef logic [$clog2(`TILE_BANK_WORDS)-1:0]  row_t;       // Row in a bank, addr[11:4]

  typedef enum logic [1:0] {
    TGT_L1   = 2'd0,  // Local scratchpad
    TGT_L2   = 2'd1,  // External memory over AXI4-Lite
    TGT_NONE = 2'd2   // Unmapped, answered with an error
  } target_e;

endpackage

`default_nettype wire

/* design/tile_rsp_merge.sv */
/*
 * Response merger
 * Keeps responses in request order and drives the core response port
 */

`default_nettype none
`timescale 1ns/100ps

`include "tile_settings.svh"

module tile_rsp_merge (
  input  wire logic                  clk_i,
  input  wire logic                  rstn_i,
  input  wire logic                  dec_valid_i,
  input  wire tile_mem_pkg::target_e dec_target_i,
  input  wire logic                  l1_rvalid_i,
  input  wire tile_mem_pkg::data_t   l1_rdata_i,
  input  wire logic                  l2_rvalid_i,
  input  wire tile_mem_pkg::data_t   l2_rdata_i,
  input  wire logic                  l2_err_i,
  output      logic                  issue_ok_o,
  output      logic                  rvalid_o,
  output      tile_mem_pkg::data_t   rdata_o,
  output      logic                  err_o
);

  localparam int CNT_W = $clog2(`TILE_MAX_OUT + 1);

  logic [CNT_W-1:0]      cnt_q;   // Responses in flight
  tile_mem_pkg::target_e tgt_q;   // Target of those responses
  logic                  none_q;  // Unmapped request answered this cycle

  // Same target only, so targets never overtake each other
  assign issue_ok_o = (cnt_q < CNT_W'(`TILE_MAX_OUT))
                      && ((cnt_q == '0) || (dec_target_i == tgt_q));

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q  <= '0;
      tgt_q  <= tile_mem_pkg::TGT_NONE;
      none_q <= 1'b0;
    end else begin
      case ({dec_valid_i, rvalid_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Issue and retire cancel out
      endcase
      if (dec_valid_i) tgt_q <= dec_target_i;
      none_q <= dec_valid_i && (dec_target_i == tile_mem_pkg::TGT_NONE);
    end
  end

  // At most one source answers in a cycle
  assign rvalid_o = l1_rvalid_i || l2_rvalid_i || none_q;

  always_comb begin
    if (l2_rvalid_i)      rdata_o = l2_rdata_i;
    else if (l1_rvalid_i) rdata_o = l1_rdata_i;
    else                  rdata_o = '0;  // Unmapped and idle read as zero
  end

  assign err_o = (l2_rvalid_i && l2_err_i) || none_q;

endmodule

`default_nettype wire

/* design/tile_settings.svh */
/*
 * Tile data path settings
 * Bus widths, address map, L1 bank geometry and response depth
 */

`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// Core data port widths
`define TILE_ADDR_W      32
`define TILE_DATA_W      32

// L1 scratchpad window, 4 KiB
`define TILE_L1_BASE     32'h1000_0000
`define TILE_L1_END      32'h1000_0FFF

// External L2 window behind the AXI4-Lite master
`define TILE_L2_BASE     32'h8000_0000
`define TILE_L2_END      32'h8FFF_FFFF

// Word-interleaved banks
`define TILE_N_BANKS     4
`define TILE_BANK_WORDS  256

// Responses allowed in flight on the core port
`define TILE_MAX_OUT     2

`endif

/* run.sh */
#!/usr/bin/env bash
# Build and run the tile data path testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_tile -o tb_tile

./obj_dir/tb_tile | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"
